//--- st_params.svh
`ifndef ST_PARAMS_SVH
`define ST_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// widths and sizes

`define ST_DATA_W       32          // host bus word and stream data
`define ST_ADDR_W       16          // block-local address, top bits already decoded
`define ST_KEEP_W       4           // one keep bit per data byte

`define ST_LANES        2
`define ST_FRAME_LEN    3           // beats per frame, last on the final beat

////////////////////////////////////////////////////////////////////////////
// register map

`define ST_ADDR_EN      'h20        // enable mask, bit n enables lane n
`define ST_ADDR_FSM_RST 'h30        // bit 0 holds generators and timers

// lane n block starts at base + n * stride
`define ST_LANE_BASE    'h20
`define ST_LANE_STRIDE  'h10

// offsets inside one lane block, word 1 at the listed offset
`define ST_OFS_TX       1           // tx words 1..3, writable
`define ST_OFS_RXD      4           // captured rx words 1..3
`define ST_OFS_RXS      7           // captured status words 1..3

// latency regs, indexed by source lane
// 0x13 lane 0 into lane 1, 0x14 lane 1 into lane 0
`define ST_ADDR_LAT     'h13

`endif

//--- st_bus_pkg.sv
`include "st_params.svh"

package st_bus_pkg;

	typedef logic [`ST_ADDR_W-1:0] io_addr_t;
	typedef logic [`ST_DATA_W-1:0] io_data_t;

	// one host bus cycle, as seen by the block
	typedef struct packed {
		logic     sel;      // block selected
		logic     sync;     // gates the read ack
		logic     rd_en;
		logic     wr_en;
		io_addr_t addr;
		io_data_t wr_data;
	} io_req_t;

	// control for one lane out of the register file
	typedef struct packed {
		logic                         en;
		io_data_t [`ST_FRAME_LEN-1:0] tx_word;  // [0] goes out first
	} lane_ctrl_t;

	// address of a word inside lane n's block
	function automatic io_addr_t lane_addr(input int unsigned lane, input int unsigned ofs);
		return io_addr_t'(`ST_LANE_BASE + lane * `ST_LANE_STRIDE + ofs);
	endfunction

endpackage

//--- st_link_pkg.sv
`include "st_params.svh"

package st_link_pkg;

	typedef logic [`ST_KEEP_W-1:0] keep_t;

	// one beat on a tx or rx stream
	typedef struct packed {
		logic                  valid;
		logic                  last;
		keep_t                 keep;
		logic [`ST_DATA_W-1:0] data;
	} stream_beat_t;

	// status word per received beat
	// bit 6 tready, bit 5 valid, bit 4 last, bits 3:0 keep, rest zero
	typedef logic [`ST_DATA_W-1:0] rx_stat_t;

	// what a lane hands to the readback mux
	typedef struct packed {
		logic [`ST_FRAME_LEN-1:0][`ST_DATA_W-1:0] rx_word;  // [0] oldest
		rx_stat_t [`ST_FRAME_LEN-1:0]             rx_stat;  // paired with rx_word
		logic [`ST_DATA_W-1:0]                    latency;  // cycles, peer start to rx
	} lane_capture_t;

	// frame generator
	typedef enum logic [2:0] {
		IDLE,
		BEAT1,
		BEAT2,
		BEAT3,
		DONE     // frame sent, wait for enable low
	} gen_state_t;

endpackage

//--- st_io_regs.sv
`timescale 1ns/100ps
`include "st_params.svh"

module st_io_regs
	import st_bus_pkg::*;
(
	input  logic       io_clk,
	input  logic       rst,
	input  io_req_t    req,
	output lane_ctrl_t lane_ctrl [`ST_LANES],
	output logic       fsm_rst
);

	logic [`ST_LANES-1:0]         en_q;             // one enable per lane
	io_data_t [`ST_FRAME_LEN-1:0] tx_q [`ST_LANES];  // tx words per lane
	logic                         wr_req;

	assign wr_req = req.sel & req.wr_en;

	////////////////////////////////////////////////////////////////////////////
	// control regs

	always_ff @(posedge io_clk) begin
		if (rst) begin
			en_q    <= '0;
			fsm_rst <= 1'b0;
		end else if (wr_req) begin
			if (req.addr == io_addr_t'(`ST_ADDR_EN))
				en_q <= req.wr_data[`ST_LANES-1:0];  // low bits only
			if (req.addr == io_addr_t'(`ST_ADDR_FSM_RST))
				fsm_rst <= req.wr_data[0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tx data words, three per lane

	always_ff @(posedge io_clk) begin
		if (wr_req) begin
			for (int n = 0; n < `ST_LANES; n++) begin
				for (int w = 0; w < `ST_FRAME_LEN; w++) begin
					if (req.addr == lane_addr(n, `ST_OFS_TX + w))
						tx_q[n][w] <= req.wr_data;
				end
			end
		end
	end

	// bundle per lane
	for (genvar n = 0; n < `ST_LANES; n++) begin : g_ctrl
		assign lane_ctrl[n] = '{en: en_q[n], tx_word: tx_q[n]};
	end

endmodule

//--- st_lane.sv
`timescale 1ns/100ps
`include "st_params.svh"

module st_lane
	import st_bus_pkg::*, st_link_pkg::*;
(
	input  logic          io_clk,
	input  logic          rst,
	input  logic          fsm_rst,        // soft reset from the host
	input  lane_ctrl_t    ctrl,
	input  logic          tx_ready,
	input  logic          peer_tx_start,  // peer's first beat is out
	input  stream_beat_t  rx,             // always accepted
	output stream_beat_t  tx,
	output logic          tx_start,
	output lane_capture_t capture
);

	gen_state_t state;
	gen_state_t state_nxt;
	logic       en_d;     // enable, one cycle late
	logic       go;       // enable rose

	logic                  lat_run;
	logic [`ST_DATA_W-1:0] lat_cnt;

	logic [`ST_FRAME_LEN-1:0][`ST_DATA_W-1:0] rx_word;
	rx_stat_t [`ST_FRAME_LEN-1:0]             rx_stat;
	rx_stat_t                                 stat_now;

	assign go = ctrl.en & ~en_d;

	////////////////////////////////////////////////////////////////////////////
	// frame generator

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (go) state_nxt = BEAT1;
			BEAT1:   if (tx_ready) state_nxt = BEAT2;
			BEAT2:   if (tx_ready) state_nxt = BEAT3;
			BEAT3:   if (tx_ready) state_nxt = DONE;   // last accepted
			DONE:    if (!ctrl.en) state_nxt = IDLE;    // rearm on enable low
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge io_clk) begin
		if (rst) begin
			state    <= IDLE;
			en_d     <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			en_d <= ctrl.en;
			if (fsm_rst) begin
				state    <= IDLE;
				tx_start <= 1'b0;
			end else begin
				state    <= state_nxt;
				tx_start <= (state == IDLE) && go;  // high in first BEAT1 cycle only
			end
		end
	end

	// beat follows state, so it holds while tx_ready is low
	always_comb begin
		tx      = '0;
		tx.keep = '1;
		case (state)
			BEAT1: begin
				tx.valid = 1'b1;
				tx.data  = ctrl.tx_word[0];
			end
			BEAT2: begin
				tx.valid = 1'b1;
				tx.data  = ctrl.tx_word[1];
			end
			BEAT3: begin
				tx.valid = 1'b1;
				tx.last  = 1'b1;
				tx.data  = ctrl.tx_word[2];
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// rx capture, newest word at the top

	assign stat_now = rx_stat_t'({tx_ready, rx.valid, rx.last, rx.keep});  // zero extended

	always_ff @(posedge io_clk) begin
		if (rst) begin
			rx_word <= '0;
			rx_stat <= '0;
		end else if (rx.valid) begin
			rx_word <= {rx.data, rx_word[`ST_FRAME_LEN-1:1]};
			rx_stat <= {stat_now, rx_stat[`ST_FRAME_LEN-1:1]};
		end
	end

	// latency timer
	// counts from the edge after the peer start up to the first rx valid cycle
	always_ff @(posedge io_clk) begin
		if (rst || fsm_rst) begin
			lat_run <= 1'b0;
			lat_cnt <= '0;
		end else if (peer_tx_start) begin
			lat_run <= 1'b1;
			lat_cnt <= '0;             // restart for every frame
		end else if (lat_run) begin
			lat_cnt <= lat_cnt + 1'b1;
			if (rx.valid)
				lat_run <= 1'b0;       // count includes the valid cycle
		end
	end

	assign capture = '{rx_word: rx_word, rx_stat: rx_stat, latency: lat_cnt};

endmodule

//--- st_rdbk_mux.sv
`timescale 1ns/100ps
`include "st_params.svh"

module st_rdbk_mux
	import st_bus_pkg::*, st_link_pkg::*;
(
	input  logic          io_clk,
	input  logic          rst,
	input  io_req_t       req,
	input  lane_ctrl_t    lane_ctrl [`ST_LANES],
	input  lane_capture_t capture [`ST_LANES],
	output io_data_t      rd_data,
	output logic          rd_ack
);

	io_data_t sel_word;   // word at req.addr, zero if unmapped
	logic     rd_req;

	assign rd_req = req.sel & req.rd_en;

	////////////////////////////////////////////////////////////////////////////
	// address decode over all lanes

	always_comb begin
		sel_word = '0;
		for (int n = 0; n < `ST_LANES; n++) begin
			for (int w = 0; w < `ST_FRAME_LEN; w++) begin
				if (req.addr == lane_addr(n, `ST_OFS_TX + w))
					sel_word = lane_ctrl[n].tx_word[w];
				if (req.addr == lane_addr(n, `ST_OFS_RXD + w))
					sel_word = capture[n].rx_word[w];
				if (req.addr == lane_addr(n, `ST_OFS_RXS + w))
					sel_word = capture[n].rx_stat[w];
			end
			// latency into lane n sits at the slot of its source lane
			if (req.addr == io_addr_t'(`ST_ADDR_LAT + (n + `ST_LANES - 1) % `ST_LANES))
				sel_word = capture[n].latency;
		end
	end

	// ack only on a synced read
	always_ff @(posedge io_clk) begin
		if (rst)
			rd_ack <= 1'b0;
		else
			rd_ack <= rd_req & req.sync;
	end

	always_ff @(posedge io_clk) begin
		if (rd_req)
			rd_data <= sel_word;  // holds between reads
	end

endmodule

//--- st_io_block.sv
`timescale 1ns/100ps
`include "st_params.svh"

module st_io_block
	import st_bus_pkg::*, st_link_pkg::*;
(
	input  logic                 io_clk,
	input  logic                 rst,
	input  io_req_t              req,
	input  logic [`ST_LANES-1:0] tx_ready,
	input  stream_beat_t         rx [`ST_LANES],
	output io_data_t             rd_data,
	output logic                 rd_ack,
	output stream_beat_t         tx [`ST_LANES]
);

	lane_ctrl_t           lane_ctrl [`ST_LANES];
	lane_capture_t        capture [`ST_LANES];
	logic                 fsm_rst;
	logic [`ST_LANES-1:0] tx_start;   // one pulse per lane per frame

	st_io_regs u_regs (
		.io_clk    (io_clk),
		.rst       (rst),
		.req       (req),
		.lane_ctrl (lane_ctrl),
		.fsm_rst   (fsm_rst)
	);

	////////////////////////////////////////////////////////////////////////////
	// lanes, each timed against the lane that feeds it

	for (genvar n = 0; n < `ST_LANES; n++) begin : g_lane
		st_lane u_lane (
			.io_clk        (io_clk),
			.rst           (rst),
			.fsm_rst       (fsm_rst),
			.ctrl          (lane_ctrl[n]),
			.tx_ready      (tx_ready[n]),
			.peer_tx_start (tx_start[(n + `ST_LANES - 1) % `ST_LANES]),  // lane n-1 feeds n
			.rx            (rx[n]),
			.tx            (tx[n]),
			.tx_start      (tx_start[n]),
			.capture       (capture[n])
		);
	end

	st_rdbk_mux u_rdbk (
		.io_clk    (io_clk),
		.rst       (rst),
		.req       (req),
		.lane_ctrl (lane_ctrl),
		.capture   (capture),
		.rd_data   (rd_data),
		.rd_ack    (rd_ack)
	);

endmodule

//--- tb_st_io_block.sv
`timescale 1ns/100ps
`include "st_params.svh"

module tb_st_io_block
	import st_bus_pkg::*, st_link_pkg::*;
();

	localparam int CLK_NS = 4;
	localparam int D0     = 5;    // lane 0 into lane 1
	localparam int D1     = 8;    // lane 1 into lane 0
	localparam int PIPE_N = 8;    // longest link delay
	localparam int N_OPS  = 62;   // planned bus operations

	logic                 io_clk;
	logic                 rst;
	io_req_t              req;
	logic [`ST_LANES-1:0] tx_ready;
	stream_beat_t         rx [`ST_LANES];
	stream_beat_t         tx [`ST_LANES];
	io_data_t             rd_data;
	logic                 rd_ack;

	// model of written regs and delivered frames
	io_data_t     m_tx  [`ST_LANES][`ST_FRAME_LEN];
	io_data_t     m_rxd [`ST_LANES][`ST_FRAME_LEN];
	io_data_t     m_rxs [`ST_LANES][`ST_FRAME_LEN];
	io_data_t     m_lat [`ST_LANES];
	stream_beat_t pipe  [`ST_LANES][PIPE_N];   // link delay lines
	int           beat_idx [`ST_LANES];
	int           got_beats [`ST_LANES];       // rx beats per lane, cumulative
	int           start_cyc [`ST_LANES];
	bit           prev_valid [`ST_LANES];
	bit           lat_wait [`ST_LANES];
	int           cyc;
	bit           ready_rand;                  // tx_ready from the lfsr
	logic [15:0]  lfsr_q;
	io_data_t     exp_q [$];
	io_addr_t     addr_q [$];

	st_io_block dut (
		.io_clk   (io_clk),
		.rst      (rst),
		.req      (req),
		.tx_ready (tx_ready),
		.rx       (rx),
		.rd_data  (rd_data),
		.rd_ack   (rd_ack),
		.tx       (tx)
	);

	always #(CLK_NS / 2) io_clk = ~io_clk;

	////////////////////////////////////////////////////////////////////////////
	// helpers

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic compare(input io_data_t got, input io_data_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED at %0t ns: %s, got %h, expected %h",
				$time, what, got, exp));
	endtask

	// fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic io_data_t draw_word();
		io_data_t v;
		v = '0;
		for (int i = 0; i < `ST_DATA_W; i++)
			v = {v[`ST_DATA_W-2:0], lfsr_bit()};  // one step per bit
		return v;
	endfunction

	function automatic io_addr_t lane_reg(input int n, input int ofs);
		return io_addr_t'(`ST_LANE_BASE + n * `ST_LANE_STRIDE + ofs);
	endfunction

	function automatic int link_delay(input int n);
		return (n == 0) ? D0 : D1;
	endfunction

	// expected readback at any address, unmapped reads as zero
	function automatic io_data_t ref_word(input io_addr_t a);
		io_data_t v;
		v = '0;
		for (int n = 0; n < `ST_LANES; n++) begin
			for (int w = 0; w < `ST_FRAME_LEN; w++) begin
				if (a == lane_reg(n, `ST_OFS_TX + w))  v = m_tx[n][w];
				if (a == lane_reg(n, `ST_OFS_RXD + w)) v = m_rxd[n][w];
				if (a == lane_reg(n, `ST_OFS_RXS + w)) v = m_rxs[n][w];
			end
		end
		if (a == io_addr_t'(`ST_ADDR_LAT))     v = m_lat[1];  // lane 0 into lane 1
		if (a == io_addr_t'(`ST_ADDR_LAT + 1)) v = m_lat[0];
		return v;
	endfunction

	// bus tasks start and end on a falling edge
	task automatic bus_write(input io_addr_t a, input io_data_t d);
		req = '{sel: 1'b1, sync: 1'b1, rd_en: 1'b0, wr_en: 1'b1, addr: a, wr_data: d};
		for (int n = 0; n < `ST_LANES; n++)
			for (int w = 0; w < `ST_FRAME_LEN; w++)
				if (a == lane_reg(n, `ST_OFS_TX + w)) m_tx[n][w] = d;
		if (a == io_addr_t'(`ST_ADDR_FSM_RST) && d[0])
			m_lat = '{default: '0};  // timers held at zero
		@(negedge io_clk);
		req = '0;
	endtask

	task automatic bus_read(input io_addr_t a, input logic sync = 1'b1);
		req = '{sel: 1'b1, sync: sync, rd_en: 1'b1, wr_en: 1'b0, addr: a, wr_data: '0};
		if (sync) begin
			exp_q.push_back(ref_word(a));
			addr_q.push_back(a);
		end
		@(negedge io_clk);
		req = '0;
		if (rd_ack !== sync)
			stop_run($sformatf("read acknowledge wrong one cycle after read of %h", a));
	endtask

	task automatic write_tx_words();
		for (int n = 0; n < `ST_LANES; n++)
			for (int w = 0; w < `ST_FRAME_LEN; w++)
				bus_write(lane_reg(n, `ST_OFS_TX + w), draw_word());
	endtask

	task automatic read_captures();
		for (int n = 0; n < `ST_LANES; n++)
			for (int w = 0; w < `ST_FRAME_LEN; w++) begin
				bus_read(lane_reg(n, `ST_OFS_RXD + w));
				bus_read(lane_reg(n, `ST_OFS_RXS + w));
			end
	endtask

	task automatic wait_frames(input int target);
		int t;
		t = 0;
		while ((got_beats[0] < target || got_beats[1] < target) && t < 200) begin
			@(negedge io_clk);
			t++;
		end
		if (t >= 200)
			stop_run("frames did not arrive on both lanes in time");
		repeat (2) @(negedge io_clk);  // let capture settle
	endtask

	////////////////////////////////////////////////////////////////////////////
	// link model, lane n feeds lane n+1 after its delay

	always @(negedge io_clk) begin : link_model
		logic [`ST_LANES-1:0] rdy;
		stream_beat_t         beat;
		stream_beat_t         out;
		int                   m;
		cyc++;
		for (int n = 0; n < `ST_LANES; n++)
			rdy[n] = ready_rand ? lfsr_bit() : 1'b1;
		tx_ready = rdy;
		for (int n = 0; n < `ST_LANES; n++) begin
			m    = (n + 1) % `ST_LANES;
			beat = '0;
			if (tx[n].valid && !prev_valid[n]) begin  // first beat, start pulse cycle
				start_cyc[n] = cyc;
				lat_wait[m]  = 1'b1;
			end
			prev_valid[n] = tx[n].valid;
			if (!rst && tx[n].valid && rdy[n]) begin
				compare(tx[n].data, m_tx[n][beat_idx[n]],
					$sformatf("lane %0d tx beat %0d data", n, beat_idx[n] + 1));
				compare(tx[n].last, beat_idx[n] == `ST_FRAME_LEN - 1,
					$sformatf("lane %0d tx beat %0d last", n, beat_idx[n] + 1));
				compare(tx[n].keep, 4'hF, $sformatf("lane %0d tx keep", n));
				beat        = tx[n];
				beat_idx[n] = (beat_idx[n] + 1) % `ST_FRAME_LEN;
			end
			out = pipe[n][link_delay(n) - 1];
			for (int i = PIPE_N - 1; i > 0; i--)
				pipe[n][i] = pipe[n][i - 1];
			pipe[n][0] = beat;
			rx[m]      = out;
			if (out.valid) begin
				for (int w = 0; w < `ST_FRAME_LEN - 1; w++) begin
					m_rxd[m][w] = m_rxd[m][w + 1];
					m_rxs[m][w] = m_rxs[m][w + 1];
				end
				m_rxd[m][`ST_FRAME_LEN-1] = out.data;
				m_rxs[m][`ST_FRAME_LEN-1] = {25'b0, rdy[m], 1'b1, out.last, 4'hF};
				if (lat_wait[m]) begin
					m_lat[m]    = cyc - start_cyc[n];
					lat_wait[m] = 1'b0;
				end
				got_beats[m]++;
			end
		end
	end

	// every acked read against the queued expectation
	always @(negedge io_clk) begin : read_checker
		io_addr_t a;
		if (!rst && rd_ack) begin
			if (exp_q.size() == 0)
				stop_run("read acknowledge seen with no read pending");
			else begin
				a = addr_q.pop_front();
				compare(rd_data, exp_q.pop_front(), $sformatf("readback of %h", a));
			end
		end
	end

	initial begin : watchdog
		#(N_OPS * 200 * CLK_NS);
		stop_run("timeout, the run did not finish within its cycle budget");
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin : stimulus
		io_clk     = 1'b0;
		rst        = 1'b1;
		req        = '0;
		tx_ready   = '1;
		rx         = '{default: '0};
		lfsr_q     = 16'd65;
		ready_rand = 1'b0;
		cyc        = 0;
		m_lat      = '{default: '0};
		for (int n = 0; n < `ST_LANES; n++) begin
			m_rxd[n] = '{default: '0};
			m_rxs[n] = '{default: '0};
			pipe[n]  = '{default: '0};
		end
		repeat (4) @(negedge io_clk);
		rst = 1'b0;

		write_tx_words();             // register write and readback
		for (int n = 0; n < `ST_LANES; n++)
			for (int w = 0; w < `ST_FRAME_LEN; w++)
				bus_read(lane_reg(n, `ST_OFS_TX + w));
		bus_read(16'h002F);
		bus_read(16'h0000);
		bus_read(lane_reg(0, `ST_OFS_TX), 1'b0);  // no sync, no ack

		bus_write(`ST_ADDR_EN, 32'h3);  // both frames, ready high
		wait_frames(3);
		read_captures();
		bus_read(`ST_ADDR_LAT);
		bus_read(`ST_ADDR_LAT + 1);

		bus_write(`ST_ADDR_EN, 32'h0);  // back-pressure frame
		write_tx_words();
		@(posedge io_clk);
		ready_rand = 1'b1;
		@(negedge io_clk);
		bus_write(`ST_ADDR_EN, 32'h3);
		wait_frames(6);
		@(posedge io_clk);
		ready_rand = 1'b0;
		@(negedge io_clk);
		read_captures();
		bus_read(`ST_ADDR_LAT);
		bus_read(`ST_ADDR_LAT + 1);
		compare(got_beats[0], 6, "beats into lane 0");
		compare(got_beats[1], 6, "beats into lane 1");

		bus_write(`ST_ADDR_FSM_RST, 32'h1);  // soft reset keeps captures
		bus_write(`ST_ADDR_FSM_RST, 32'h0);
		bus_read(`ST_ADDR_LAT);
		bus_read(`ST_ADDR_LAT + 1);
		for (int n = 0; n < `ST_LANES; n++)
			for (int w = 0; w < `ST_FRAME_LEN; w++)
				bus_read(lane_reg(n, `ST_OFS_RXD + w));

		repeat (2) @(negedge io_clk);
		if (exp_q.size() != 0) begin
			$display("reads were left without an acknowledge");
			$display("Verification failed");
			$fatal(1);
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

//--- sim.f
+incdir+.
st_bus_pkg.sv
st_link_pkg.sv
st_io_regs.sv
st_lane.sv
st_rdbk_mux.sv
st_io_block.sv
tb_st_io_block.sv
